//--- compile.f
hw/timer_pkg.sv
hw/axilite2regctl.sv
hw/timer_regs.sv
hw/timer_fsm.sv
hw/down_counter.sv
hw/timer_periph_top.sv
dv/tb_timer_periph.sv

//--- dv/tb_timer_periph.sv
`timescale 1ns/1ps

module tb_timer_periph;

	import timer_pkg::*;

	localparam int data_width = def_data_width;
	localparam int addr_width = def_addr_width;
	localparam int reg_idx_width = def_reg_idx_width;
	localparam int clk_period = 20;
	localparam int small_reload_max = 23;
	localparam int large_reload_max = 2047;
	localparam int poll_limit = 64;
	// operations in the run, and the bus cycles one of them takes at most
	localparam int num_ops = 200;
	localparam int op_cycles = 8;
	localparam int watchdog_cycles = num_ops * (op_cycles + small_reload_max) + 1000;

	logic                  clk;
	logic                  resetn;
	logic [addr_width-1:0] s_axi_awaddr;
	logic [2:0]            s_axi_awprot;
	logic                  s_axi_awvalid;
	logic                  s_axi_awready;
	logic [data_width-1:0] s_axi_wdata;
	logic                  s_axi_wvalid;
	logic                  s_axi_wready;
	logic [1:0]            s_axi_bresp;
	logic                  s_axi_bvalid;
	logic                  s_axi_bready;
	logic [addr_width-1:0] s_axi_araddr;
	logic [2:0]            s_axi_arprot;
	logic                  s_axi_arvalid;
	logic                  s_axi_arready;
	logic [data_width-1:0] s_axi_rdata;
	logic [1:0]            s_axi_rresp;
	logic                  s_axi_rvalid;
	logic                  s_axi_rready;
	logic                  irq;

	integer seed;
	// shadow copies of the software visible state
	logic [ctrl_width-1:0] ctrl_m;
	logic [data_width-1:0] load_m;
	logic                  expired_m;

	timer_periph_top #(
		.data_width    (data_width),
		.addr_width    (addr_width),
		.reg_idx_width (reg_idx_width)
	) i_timer_periph_top (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// covers the bus traffic plus the longest expiry wait per operation
	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog timeout, the run hung after %0d cycles", watchdog_cycles);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog");
	end

	task automatic check_value(input string name, input logic [data_width-1:0] actual,
		input logic [data_width-1:0] expected);
		if (actual !== expected) begin
			$display("ERROR: %s actual 0x%h expected 0x%h", name, actual, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run aborted");
	endtask

	// register index sits in the upper address bits
	function automatic logic [addr_width-1:0] reg_addr(input int idx);
		return addr_width'(idx) << (addr_width - reg_idx_width);
	endfunction

	// ctrl keeps three bits, status bit zero is write one to clear
	task automatic model_write(input int idx, input logic [data_width-1:0] data);
		if (idx == reg_ctrl)
			ctrl_m = data[ctrl_width-1:0];
		else if (idx == reg_load)
			load_m = data;
		else if (idx == reg_status && data[status_expired_bit])
			expired_m = 1'b0;
	endtask

	// count is not modelled, unmapped indices read zero
	function automatic logic [data_width-1:0] expected_read(input int idx);
		logic [data_width-1:0] value;
		value = '0;
		if (idx == reg_ctrl)
			value[ctrl_width-1:0] = ctrl_m;
		else if (idx == reg_load)
			value = load_m;
		else if (idx == reg_status)
			value[status_expired_bit] = expired_m;
		return value;
	endfunction

	// valids stay up until ready is seen, and drop after that edge
	task automatic finish_write_request();
		@(negedge clk);
		while (!(s_axi_awready && s_axi_wready))
			@(negedge clk);
		@(negedge clk);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid = 1'b0;
	endtask

	task automatic finish_write_response();
		while (!s_axi_bvalid)
			@(negedge clk);
		check_value("bresp", s_axi_bresp, 2'b00);
		s_axi_bready = 1'b1;
		@(negedge clk);
		s_axi_bready = 1'b0;
		check_value("bvalid", s_axi_bvalid, 1'b0);
	endtask

	task automatic start_write(input int idx, input logic [data_width-1:0] data);
		s_axi_awaddr = reg_addr(idx);
		s_axi_awprot = 3'($random(seed));
		s_axi_wdata = data;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid = 1'b1;
	endtask

	task automatic axil_write(input int idx, input logic [data_width-1:0] data);
		start_write(idx, data);
		finish_write_request();
		finish_write_response();
		model_write(idx, data);
	endtask

	// rready is held off for hold_cycles while rvalid and rdata must stay put
	task automatic axil_read(input int idx, input int hold_cycles,
		output logic [data_width-1:0] data);
		s_axi_araddr = reg_addr(idx);
		s_axi_arprot = 3'($random(seed));
		s_axi_arvalid = 1'b1;
		@(negedge clk);
		while (!s_axi_arready)
			@(negedge clk);
		@(negedge clk);
		s_axi_arvalid = 1'b0;
		while (!s_axi_rvalid)
			@(negedge clk);
		check_value("rresp", s_axi_rresp, 2'b00);
		data = s_axi_rdata;
		repeat (hold_cycles) begin
			@(negedge clk);
			check_value("rvalid", s_axi_rvalid, 1'b1);
			check_value("rdata", s_axi_rdata, data);
		end
		s_axi_rready = 1'b1;
		@(negedge clk);
		s_axi_rready = 1'b0;
	endtask

	task automatic read_and_compare(input int idx, input string name);
		logic [data_width-1:0] data;
		axil_read(idx, 0, data);
		check_value(name, data, expected_read(idx));
	endtask

	task automatic wait_for_expiry();
		logic [data_width-1:0] status;
		int polls;
		status = '0;
		polls = 0;
		while (!status[status_expired_bit]) begin
			if (polls == poll_limit) begin
				fail_run("status never showed the expired flag");
			end else begin
				axil_read(reg_status, 0, status);
				polls++;
			end
		end
		expired_m = 1'b1;
	endtask

	initial begin
		logic [data_width-1:0] data;
		logic [data_width-1:0] prev;
		logic [data_width-1:0] reload;
		logic [ctrl_width-1:0] ctrl;
		int idx;
		int hold;
		int i;
		seed = 32'hbe46b167;
		ctrl_m = '0;
		load_m = '0;
		expired_m = 1'b0;
		resetn = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awprot = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arprot = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		repeat (5) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		check_value("irq", irq, 1'b0);
		check_value("awready", s_axi_awready, 1'b0);
		check_value("wready", s_axi_wready, 1'b0);
		check_value("bvalid", s_axi_bvalid, 1'b0);
		check_value("arready", s_axi_arready, 1'b0);
		check_value("rvalid", s_axi_rvalid, 1'b0);

		// readback with the timer stopped, enable never written as one
		for (i = 0; i < 16; i++) begin
			case ($unsigned($random(seed)) % 4)
				0: axil_write(reg_load, $random(seed));
				1: axil_write(reg_ctrl, $random(seed) & ~(1 << ctrl_enable_bit));
				2: begin
					axil_read(reg_count, 0, prev);
					axil_write(reg_count, $random(seed));
					axil_read(reg_count, 0, data);
					check_value("count", data, prev);
				end
				default: begin
					idx = 4 + $unsigned($random(seed)) % ((1 << reg_idx_width) - 4);
					axil_write(idx, $random(seed));
					read_and_compare(idx, "unmapped");
				end
			endcase
			read_and_compare(reg_ctrl, "ctrl");
			read_and_compare(reg_load, "load");
			read_and_compare(reg_status, "status");
		end

		// one-shot, counter must park at zero after expiry
		reload = 1 + $unsigned($random(seed)) % small_reload_max;
		ctrl = '0;
		ctrl[ctrl_enable_bit] = 1'b1;
		ctrl[ctrl_irq_en_bit] = 1'b1;
		axil_write(reg_load, reload);
		axil_write(reg_ctrl, ctrl);
		wait_for_expiry();
		for (i = 0; i < 4; i++) begin
			axil_read(reg_count, 0, data);
			check_value("count", data, '0);
		end
		check_value("irq", irq, expired_m && ctrl_m[ctrl_irq_en_bit]);

		// writing zero to status keeps the flag, writing one clears it
		axil_write(reg_status, $random(seed) & ~(1 << status_expired_bit));
		read_and_compare(reg_status, "status");
		check_value("irq", irq, expired_m && ctrl_m[ctrl_irq_en_bit]);
		axil_write(reg_status, 1 << status_expired_bit);
		read_and_compare(reg_status, "status");
		check_value("irq", irq, expired_m && ctrl_m[ctrl_irq_en_bit]);

		// large reload, reads only ever go down
		axil_write(reg_ctrl, 0);
		reload = large_reload_max / 2 + $unsigned($random(seed)) % (large_reload_max / 2);
		axil_write(reg_load, reload);
		ctrl = '0;
		ctrl[ctrl_enable_bit] = 1'b1;
		axil_write(reg_ctrl, ctrl);
		prev = reload;
		for (i = 0; i < 8; i++) begin
			axil_read(reg_count, 0, data);
			check_value("count_not_increasing", data <= prev, 1'b1);
			prev = data;
		end
		axil_write(reg_ctrl, 0);
		read_and_compare(reg_status, "status");

		// periodic, period of 9 or more cycles exceeds the read spacing
		reload = 8 + $unsigned($random(seed)) % (small_reload_max - 7);
		axil_write(reg_load, reload);
		ctrl = '0;
		ctrl[ctrl_enable_bit] = 1'b1;
		ctrl[ctrl_periodic_bit] = 1'b1;
		axil_write(reg_ctrl, ctrl);
		wait_for_expiry();
		axil_write(reg_status, 1 << status_expired_bit);
		wait_for_expiry();
		prev = reload;
		for (i = 0; i < 12; i++) begin
			axil_read(reg_count, 0, data);
			check_value("count_within_reload", data <= reload, 1'b1);
			check_value("count_stuck_at_zero", (data == 0) && (prev == 0), 1'b0);
			prev = data;
		end
		check_value("irq", irq, 1'b0);
		ctrl[ctrl_enable_bit] = 1'b0;
		axil_write(reg_ctrl, ctrl);
		axil_read(reg_count, 0, prev);
		axil_read(reg_count, 0, data);
		check_value("count_frozen", data, prev);
		axil_write(reg_status, 1 << status_expired_bit);
		read_and_compare(reg_status, "status");

		// pending write response blocks a second write
		hold = 2 + $unsigned($random(seed)) % 8;
		data = $random(seed);
		start_write(reg_load, data);
		finish_write_request();
		model_write(reg_load, data);
		reload = $random(seed);
		start_write(reg_load, reload);
		for (i = 0; i < hold; i++) begin
			@(negedge clk);
			check_value("bvalid", s_axi_bvalid, 1'b1);
			check_value("awready", s_axi_awready, 1'b0);
			check_value("wready", s_axi_wready, 1'b0);
		end
		s_axi_bready = 1'b1;
		@(negedge clk);
		s_axi_bready = 1'b0;
		finish_write_request();
		finish_write_response();
		model_write(reg_load, reload);
		read_and_compare(reg_load, "load");

		// held rready while the counter keeps moving underneath
		reload = 8 + $unsigned($random(seed)) % (small_reload_max - 7);
		axil_write(reg_load, reload);
		axil_write(reg_ctrl, ctrl | (1 << ctrl_enable_bit));
		axil_read(reg_count, 2 + $unsigned($random(seed)) % 8, data);
		check_value("count_within_reload", data <= reload, 1'b1);
		axil_write(reg_ctrl, 0);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- hw/axilite2regctl.sv
`timescale 1ns/1ps

module axilite2regctl #(
	parameter int data_width = timer_pkg::def_data_width,
	parameter int addr_width = timer_pkg::def_addr_width,
	parameter int reg_idx_width = timer_pkg::def_reg_idx_width
) (
	input  logic                     clk,
	input  logic                     resetn,

	// register side
	output logic                     rd_en,
	output logic [reg_idx_width-1:0] rd_addr,
	input  logic [data_width-1:0]    rd_data,
	output logic                     wr_en,
	output logic [reg_idx_width-1:0] wr_addr,
	output logic [data_width-1:0]    wr_data,

	// axi4-lite slave
	input  logic [addr_width-1:0]    s_axi_awaddr,
	input  logic [2:0]               s_axi_awprot,
	input  logic                     s_axi_awvalid,
	output logic                     s_axi_awready,
	input  logic [data_width-1:0]    s_axi_wdata,
	input  logic                     s_axi_wvalid,
	output logic                     s_axi_wready,
	output logic [1:0]               s_axi_bresp,
	output logic                     s_axi_bvalid,
	input  logic                     s_axi_bready,
	input  logic [addr_width-1:0]    s_axi_araddr,
	input  logic [2:0]               s_axi_arprot,
	input  logic                     s_axi_arvalid,
	output logic                     s_axi_arready,
	output logic [data_width-1:0]    s_axi_rdata,
	output logic [1:0]               s_axi_rresp,
	output logic                     s_axi_rvalid,
	input  logic                     s_axi_rready
);

	// write channel state
	logic                  wr_ready_q;
	logic                  aw_en_q;
	logic [addr_width-1:0] awaddr_q;
	logic                  bvalid_q;
	logic                  wr_accept;

	// read channel state
	logic                  arready_q;
	logic                  rvalid_q;

	// address and data must both be present, and no response may be pending
	assign wr_accept = !wr_ready_q && s_axi_awvalid && s_axi_wvalid && aw_en_q;

	// awready and wready always move together, so one flop drives both
	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ready_q <= 1'b0;
			aw_en_q <= 1'b1;
		end else if (wr_accept) begin
			wr_ready_q <= 1'b1;
			aw_en_q <= 1'b0;
		end else if (s_axi_bready && bvalid_q) begin
			// response taken, open the channel again
			wr_ready_q <= 1'b0;
			aw_en_q <= 1'b1;
		end else begin
			wr_ready_q <= 1'b0;
		end
	end

	// hold the write address for the strobe cycle
	always_ff @(posedge clk) begin
		if (!resetn) begin
			awaddr_q <= '0;
		end else if (wr_accept) begin
			awaddr_q <= s_axi_awaddr;
		end
	end

	// one-cycle write strobe in the ready cycle
	assign wr_en = wr_ready_q && s_axi_wvalid && s_axi_awvalid;
	assign wr_addr = awaddr_q[addr_width-1 -: reg_idx_width];
	assign wr_data = s_axi_wdata;

	// bvalid rises after the strobe and waits for bready
	always_ff @(posedge clk) begin
		if (!resetn) begin
			bvalid_q <= 1'b0;
		end else if (wr_en && !bvalid_q) begin
			bvalid_q <= 1'b1;
		end else if (s_axi_bready && bvalid_q) begin
			bvalid_q <= 1'b0;
		end
	end

	// arready pulses one cycle per arvalid
	always_ff @(posedge clk) begin
		if (!resetn) begin
			arready_q <= 1'b0;
		end else if (!arready_q && s_axi_arvalid) begin
			arready_q <= 1'b1;
		end else begin
			arready_q <= 1'b0;
		end
	end

	// read strobe only when no read data is still waiting
	assign rd_en = arready_q && s_axi_arvalid && !rvalid_q;
	// araddr is still valid during the arready cycle
	assign rd_addr = s_axi_araddr[addr_width-1 -: reg_idx_width];

	// rvalid follows the strobe, held until rready
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rvalid_q <= 1'b0;
		end else if (rd_en) begin
			rvalid_q <= 1'b1;
		end else if (rvalid_q && s_axi_rready) begin
			rvalid_q <= 1'b0;
		end
	end

	// bus outputs
	assign s_axi_awready = wr_ready_q;
	assign s_axi_wready = wr_ready_q;
	assign s_axi_bvalid = bvalid_q;
	assign s_axi_arready = arready_q;
	assign s_axi_rvalid = rvalid_q;
	// rd_data is already a register in the register block
	assign s_axi_rdata = rd_data;
	// always OKAY, prot fields are not checked
	assign s_axi_bresp = 2'b00;
	assign s_axi_rresp = 2'b00;

	// a response is never withdrawn before the master takes it
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid);

	// no register access may leak out of a reset cycle
	a_no_strobe_in_reset: assert property (@(posedge clk)
		!resetn |=> !wr_en && !rd_en);

endmodule

//--- hw/down_counter.sv
`timescale 1ns/1ps

module down_counter #(
	parameter int data_width = timer_pkg::def_data_width
) (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  load,
	input  logic [data_width-1:0] load_value,
	input  logic                  en,
	output logic [data_width-1:0] value,
	output logic                  zero
);

	logic [data_width-1:0] value_q;

	// load wins over en
	// decrement saturates at zero
	always_ff @(posedge clk) begin
		if (!resetn) begin
			value_q <= '0;
		end else if (load) begin
			value_q <= load_value;
		end else if (en && !zero) begin
			value_q <= value_q - 1'b1;
		end
	end

	assign value = value_q;
	assign zero = (value_q == '0);

	// without a load, a counter at zero stays at zero
	a_no_wrap: assert property (@(posedge clk) disable iff (!resetn)
		zero && !load |=> zero);

endmodule

//--- hw/timer_fsm.sv
`timescale 1ns/1ps

module timer_fsm (
	input  logic clk,
	input  logic resetn,
	input  logic enable,
	input  logic periodic,
	input  logic cnt_zero,
	output logic cnt_load,
	output logic cnt_en,
	output logic expire_pulse
);

	import timer_pkg::*;

	timer_state_t state_q;
	timer_state_t state_d;
	logic         in_run;

	always_ff @(posedge clk) begin
		if (!resetn)
			state_q <= st_idle;
		else
			state_q <= state_d;
	end

	// dropping enable returns any state to idle
	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (enable)
					state_d = st_run;
			end
			st_run: begin
				if (!enable)
					state_d = st_idle;
				else if (cnt_zero && !periodic)
					state_d = st_done;
			end
			st_done: begin
				if (!enable)
					state_d = st_idle;
			end
			default: state_d = st_idle;
		endcase
	end

	assign in_run = (state_q == st_run) && enable;

	// load on start, and reload on expiry in periodic mode
	assign cnt_load = ((state_q == st_idle) && enable) || (in_run && cnt_zero && periodic);
	// counter stops as soon as enable is gone
	assign cnt_en = in_run;
	assign expire_pulse = in_run && cnt_zero;

	// a load always leads into counting
	a_load_then_run: assert property (@(posedge clk) disable iff (!resetn)
		cnt_load |=> state_q == st_run);

endmodule

//--- hw/timer_periph_top.sv
`timescale 1ns/1ps

module timer_periph_top #(
	parameter int data_width = timer_pkg::def_data_width,
	parameter int addr_width = timer_pkg::def_addr_width,
	parameter int reg_idx_width = timer_pkg::def_reg_idx_width
) (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic [addr_width-1:0] s_axi_awaddr,
	input  logic [2:0]            s_axi_awprot,
	input  logic                  s_axi_awvalid,
	output logic                  s_axi_awready,
	input  logic [data_width-1:0] s_axi_wdata,
	input  logic                  s_axi_wvalid,
	output logic                  s_axi_wready,
	output logic [1:0]            s_axi_bresp,
	output logic                  s_axi_bvalid,
	input  logic                  s_axi_bready,
	input  logic [addr_width-1:0] s_axi_araddr,
	input  logic [2:0]            s_axi_arprot,
	input  logic                  s_axi_arvalid,
	output logic                  s_axi_arready,
	output logic [data_width-1:0] s_axi_rdata,
	output logic [1:0]            s_axi_rresp,
	output logic                  s_axi_rvalid,
	input  logic                  s_axi_rready,
	output logic                  irq
);

	// register strobes between bridge and register block
	logic                     rd_en;
	logic [reg_idx_width-1:0] rd_addr;
	logic [data_width-1:0]    rd_data;
	logic                     wr_en;
	logic [reg_idx_width-1:0] wr_addr;
	logic [data_width-1:0]    wr_data;

	// timer control and status
	logic                     enable;
	logic                     periodic;
	logic [data_width-1:0]    reload_value;
	logic                     cnt_load;
	logic                     cnt_en;
	logic                     cnt_zero;
	logic [data_width-1:0]    cnt_value;
	logic                     expire_pulse;

	axilite2regctl #(
		.data_width    (data_width),
		.addr_width    (addr_width),
		.reg_idx_width (reg_idx_width)
	) i_axilite2regctl (.*);

	timer_regs #(
		.data_width    (data_width),
		.reg_idx_width (reg_idx_width)
	) i_timer_regs (.*);

	timer_fsm i_timer_fsm (.*);

	down_counter #(
		.data_width (data_width)
	) i_down_counter (
		.clk        (clk),
		.resetn     (resetn),
		.load       (cnt_load),
		.load_value (reload_value),
		.en         (cnt_en),
		.value      (cnt_value),
		.zero       (cnt_zero)
	);

endmodule

//--- hw/timer_pkg.sv
package timer_pkg;

	// register map, one index per 32-bit word
	localparam int reg_ctrl = 0;
	localparam int reg_load = 1;
	localparam int reg_count = 2;
	localparam int reg_status = 3;

	// control register fields
	localparam int ctrl_enable_bit = 0;
	localparam int ctrl_periodic_bit = 1;
	localparam int ctrl_irq_en_bit = 2;
	localparam int ctrl_width = 3;

	// status register fields
	// expired is sticky, write one to clear
	localparam int status_expired_bit = 0;

	// default bus and index widths
	localparam int def_data_width = 32;
	localparam int def_addr_width = 10;
	localparam int def_reg_idx_width = 8;

	// timer state machine encoding
	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_done
	} timer_state_t;

endpackage

//--- hw/timer_regs.sv
`timescale 1ns/1ps

module timer_regs #(
	parameter int data_width = timer_pkg::def_data_width,
	parameter int reg_idx_width = timer_pkg::def_reg_idx_width
) (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic                     rd_en,
	input  logic [reg_idx_width-1:0] rd_addr,
	input  logic                     wr_en,
	input  logic [reg_idx_width-1:0] wr_addr,
	input  logic [data_width-1:0]    wr_data,
	input  logic [data_width-1:0]    cnt_value,
	input  logic                     expire_pulse,
	output logic [data_width-1:0]    rd_data,
	output logic                     enable,
	output logic                     periodic,
	output logic [data_width-1:0]    reload_value,
	output logic                     irq
);

	import timer_pkg::*;

	logic [ctrl_width-1:0] ctrl_q;
	logic [data_width-1:0] load_q;
	logic                  expired_q;
	logic                  irq_q;
	logic [data_width-1:0] rd_data_q;
	logic [data_width-1:0] rd_mux;
	logic                  status_wr;

	assign status_wr = wr_en && (wr_addr == reg_idx_width'(reg_status));

	// ctrl and reload are plain rw, count and unmapped writes drop
	always_ff @(posedge clk) begin
		if (!resetn) begin
			ctrl_q <= '0;
			load_q <= '0;
		end else if (wr_en) begin
			if (wr_addr == reg_idx_width'(reg_ctrl))
				ctrl_q <= wr_data[ctrl_width-1:0];
			if (wr_addr == reg_idx_width'(reg_load))
				load_q <= wr_data;
		end
	end

	// sticky expiry, a new expiry beats a same-cycle clear
	always_ff @(posedge clk) begin
		if (!resetn) begin
			expired_q <= 1'b0;
		end else if (expire_pulse) begin
			expired_q <= 1'b1;
		end else if (status_wr && wr_data[status_expired_bit]) begin
			expired_q <= 1'b0;
		end
	end

	// level interrupt, one cycle behind the flag
	always_ff @(posedge clk) begin
		if (!resetn)
			irq_q <= 1'b0;
		else
			irq_q <= expired_q && ctrl_q[ctrl_irq_en_bit];
	end

	always_comb begin
		rd_mux = '0;
		if (rd_addr == reg_idx_width'(reg_ctrl))
			rd_mux[ctrl_width-1:0] = ctrl_q;
		else if (rd_addr == reg_idx_width'(reg_load))
			rd_mux = load_q;
		else if (rd_addr == reg_idx_width'(reg_count))
			rd_mux = cnt_value;
		else if (rd_addr == reg_idx_width'(reg_status))
			rd_mux[status_expired_bit] = expired_q;
	end

	// snapshot on the strobe, stays put while rvalid waits
	always_ff @(posedge clk) begin
		if (!resetn)
			rd_data_q <= '0;
		else if (rd_en)
			rd_data_q <= rd_mux;
	end

	assign rd_data = rd_data_q;
	assign enable = ctrl_q[ctrl_enable_bit];
	assign periodic = ctrl_q[ctrl_periodic_bit];
	assign reload_value = load_q;
	assign irq = irq_q;

	// the flag only drops in the cycle after a status write
	a_expired_sticky: assert property (@(posedge clk) disable iff (!resetn)
		$fell(expired_q) |-> $past(status_wr));

endmodule
